// ==== logic/replay_pkg.sv ====
// shared widths, register map and stream types, imported by every replay engine RTL file
`default_nettype none

package replay_pkg;

   // stream and register widths
   localparam int DATA_WIDTH      = 64;
   localparam int KEEP_WIDTH      = 8;
   localparam int REG_WIDTH       = 32;
   localparam int REG_ADDR_WIDTH  = 3;

   localparam int NUM_QUEUES_DEF  = 4;   // top level default queue count
   localparam int QUEUE_DEPTH_DEF = 16;  // words per queue

   // register word addresses
   localparam logic [REG_ADDR_WIDTH-1:0] REG_ENABLE     = 3'd0;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_START      = 3'd1;  // self-clearing
   localparam logic [REG_ADDR_WIDTH-1:0] REG_COUNT_BASE = 3'd2;  // one count per queue
   localparam logic [REG_ADDR_WIDTH-1:0] REG_STATUS     = 3'd6;

   // sideband carried with each packet
   typedef struct packed {
      logic [15:0] pkt_len;
      logic [7:0]  src_port;  // one-hot
      logic [7:0]  dst_port;  // one-hot
   } tuser_t;

   typedef struct packed {
      logic                  valid;
      logic [DATA_WIDTH-1:0] data;
      logic [KEEP_WIDTH-1:0] keep;
      logic                  last;
      tuser_t                user;
   } stream_word_t;

   typedef struct packed {
      logic [23:0] reserved;
      logic [7:0]  queues;  // one bit per queue
   } reg_mask_t;

   // register data, decoded by address as a queue mask or a replay count
   typedef union packed {
      reg_mask_t            mask;
      logic [REG_WIDTH-1:0] count;
   } reg_word_u;

endpackage

`default_nettype wire

// ==== logic/replay_regs.sv ====
// control and status register bank, written and read by single-cycle strobes from the host
`timescale 1ns/1ps
`default_nettype none

module replay_regs import replay_pkg::*; #(
   parameter int NUM_QUEUES = NUM_QUEUES_DEF
) (
   input  logic                      axis_aclk,
   input  logic                      rst,
   input  logic                      reg_wr,
   input  logic                      reg_rd,
   input  logic [REG_ADDR_WIDTH-1:0] reg_addr,
   input  reg_word_u                 reg_wdata,
   input  logic [NUM_QUEUES-1:0]     ready,
   output reg_word_u                 reg_rdata,
   output logic                      reg_rvalid,
   output logic [NUM_QUEUES-1:0]     cap_enable,
   output logic [NUM_QUEUES-1:0]     start,
   output logic [REG_WIDTH-1:0]      counts [NUM_QUEUES]
);

   logic [REG_ADDR_WIDTH-1:0] cnt_idx;
   logic                      cnt_hit;
   logic [NUM_QUEUES-1:0]     count_nz;
   reg_word_u                 rd_mux;

   assign cnt_idx = reg_addr - REG_COUNT_BASE;
   // count window sits between the start and status words
   assign cnt_hit = (reg_addr >= REG_COUNT_BASE) && (reg_addr < REG_STATUS) &&
                    (int'(cnt_idx) < NUM_QUEUES);

   always_comb begin
      for (int q = 0; q < NUM_QUEUES; q++) begin
         count_nz[q] = |counts[q];
      end
   end

   always_ff @(posedge axis_aclk) begin
      if (rst) begin
         cap_enable <= '0;
         start      <= '0;
         reg_rvalid <= 1'b0;
         for (int q = 0; q < NUM_QUEUES; q++) begin
            counts[q] <= '0;
         end
      end else begin
         start      <= '0;      // pulse lasts one cycle
         reg_rvalid <= reg_rd;
         if (reg_wr) begin
            if (reg_addr == REG_ENABLE) begin
               cap_enable <= reg_wdata.mask.queues[NUM_QUEUES-1:0];
            end
            // only queues with a count and a stored packet may start
            if (reg_addr == REG_START) begin
               start <= reg_wdata.mask.queues[NUM_QUEUES-1:0] & count_nz & ready;
            end
            for (int q = 0; q < NUM_QUEUES; q++) begin
               if (cnt_hit && int'(cnt_idx) == q) begin
                  counts[q] <= reg_wdata.count;
               end
            end
         end
      end
   end

   // read mux, start word always reads back zero
   always_comb begin
      rd_mux = '0;
      if (reg_addr == REG_ENABLE) begin
         rd_mux.mask.queues[NUM_QUEUES-1:0] = cap_enable;
      end else if (reg_addr == REG_STATUS) begin
         rd_mux.mask.queues[NUM_QUEUES-1:0] = ready;  // queues holding a packet
      end
      for (int q = 0; q < NUM_QUEUES; q++) begin
         if (cnt_hit && int'(cnt_idx) == q) begin
            rd_mux.count = counts[q];
         end
      end
   end

   always_ff @(posedge axis_aclk) begin
      if (reg_rd) begin
         reg_rdata <= rd_mux;
      end
   end

endmodule

`default_nettype wire

// ==== logic/capture_demux.sv ====
// input side steering each host packet to the queue named by its source port
`timescale 1ns/1ps
`default_nettype none

module capture_demux import replay_pkg::*; #(
   parameter int NUM_QUEUES = NUM_QUEUES_DEF
) (
   input  logic                  axis_aclk,
   input  logic                  rst,
   input  stream_word_t          in_word,
   input  logic [NUM_QUEUES-1:0] cap_enable,
   output logic [NUM_QUEUES-1:0] q_wr,
   output logic                  q_first,
   output stream_word_t          q_word
);

   logic                  in_pkt;    // inside a packet, past its first word
   logic [NUM_QUEUES-1:0] sel_hold;  // queue chosen on the first word
   logic [NUM_QUEUES-1:0] src_bits;
   logic [NUM_QUEUES-1:0] src_low;
   logic [NUM_QUEUES-1:0] sel_now;
   logic [NUM_QUEUES-1:0] cur_sel;
   logic                  first;

   assign first    = in_word.valid && !in_pkt;
   assign src_bits = in_word.user.src_port[NUM_QUEUES-1:0];

   // lowest set source bit decides the queue
   assign src_low = src_bits & (~src_bits + 1'b1);
   assign sel_now = src_low & cap_enable;  // zero here drops the packet

   // the choice is frozen until last, enable changes mid-packet have no effect
   assign cur_sel = first ? sel_now : sel_hold;

   always_comb begin
      q_wr    = in_word.valid ? cur_sel : '0;
      q_first = first;
      q_word  = in_word;
      q_word.valid = |q_wr;
   end

   always_ff @(posedge axis_aclk) begin
      if (rst) begin
         in_pkt   <= 1'b0;
         sel_hold <= '0;
      end else begin
         if (in_word.valid) begin
            in_pkt <= !in_word.last;
         end
         if (first) begin
            sel_hold <= sel_now;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/queue_store.sv ====
// single-packet on-chip store for one queue, written by capture and read by replay
`timescale 1ns/1ps
`default_nettype none

module queue_store import replay_pkg::*; #(
   parameter int  QUEUE_DEPTH = QUEUE_DEPTH_DEF,
   localparam int AW          = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1
) (
   input  logic          axis_aclk,
   input  logic          rst,
   input  logic          wr,
   input  logic          first,
   input  stream_word_t  wr_word,
   input  logic          rd,
   input  logic [AW-1:0] rd_addr,
   output stream_word_t  rd_word,
   output logic [AW:0]   pkt_len_words,
   output logic          pkt_ready
);

   logic [DATA_WIDTH-1:0] mem_data [QUEUE_DEPTH];
   logic [KEEP_WIDTH-1:0] mem_keep [QUEUE_DEPTH];
   tuser_t                hdr_user;   // sideband of the first word
   logic [AW:0]           wr_ptr;
   logic [AW:0]           wr_idx;
   logic                  room;
   logic [DATA_WIDTH-1:0] rd_data;
   logic [KEEP_WIDTH-1:0] rd_keep;
   tuser_t                rd_user;
   logic                  rd_valid;
   logic                  rd_last;

   assign wr_idx = first ? '0 : wr_ptr;  // new packet overwrites from the top
   assign room   = wr_idx < (AW+1)'(QUEUE_DEPTH);

   always_ff @(posedge axis_aclk) begin
      if (wr && room) begin
         mem_data[wr_idx[AW-1:0]] <= wr_word.data;
         mem_keep[wr_idx[AW-1:0]] <= wr_word.keep;
      end
      if (wr && first) begin
         hdr_user <= wr_word.user;
      end
      if (wr && wr_word.last) begin
         pkt_len_words <= room ? wr_idx + 1'b1 : wr_idx;  // overflow words not counted
      end
      if (rd) begin
         rd_data <= mem_data[rd_addr];
         rd_keep <= mem_keep[rd_addr];
         rd_user <= hdr_user;
      end
   end

   always_ff @(posedge axis_aclk) begin
      if (rst) begin
         wr_ptr    <= '0;
         pkt_ready <= 1'b0;
         rd_valid  <= 1'b0;
         rd_last   <= 1'b0;
      end else begin
         if (wr) begin
            wr_ptr <= room ? wr_idx + 1'b1 : wr_idx;
         end
         if (wr && wr_word.last) begin
            pkt_ready <= 1'b1;
         end else if (wr && first) begin
            pkt_ready <= 1'b0;
         end
         rd_valid <= rd;
         rd_last  <= rd && ({1'b0, rd_addr} == pkt_len_words - 1'b1);
      end
   end

   always_comb begin
      rd_word.valid = rd_valid;
      rd_word.data  = rd_data;
      rd_word.keep  = rd_keep;
      rd_word.last  = rd_last;
      rd_word.user  = rd_user;
   end

endmodule

`default_nettype wire

// ==== logic/replay_engine.sv ====
// output side scheduler that replays each started queue's packet on the shared stream
`timescale 1ns/1ps
`default_nettype none

module replay_engine import replay_pkg::*; #(
   parameter int  NUM_QUEUES  = NUM_QUEUES_DEF,
   parameter int  QUEUE_DEPTH = QUEUE_DEPTH_DEF,
   localparam int AW          = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1,
   localparam int QW          = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1
) (
   input  logic                  axis_aclk,
   input  logic                  rst,
   input  logic [NUM_QUEUES-1:0] start,
   input  logic [REG_WIDTH-1:0]  counts [NUM_QUEUES],
   input  stream_word_t          rd_words [NUM_QUEUES],
   input  logic [AW:0]           lens [NUM_QUEUES],
   output logic [NUM_QUEUES-1:0] rd,
   output logic [AW-1:0]         rd_addr,
   output stream_word_t          out_word
);

   logic [NUM_QUEUES-1:0] pending;
   logic [NUM_QUEUES-1:0] cur_bit;
   logic [NUM_QUEUES-1:0] busy_mask;
   logic                  active;
   logic [QW-1:0]         cur_q;
   logic [QW-1:0]         pick_q;
   logic [QW-1:0]         out_q;     // queue whose read data arrives this cycle
   logic [AW-1:0]         rd_ptr;
   logic [AW:0]           cur_len;
   logic [REG_WIDTH-1:0]  copies_left;
   logic                  end_of_copy;
   stream_word_t          sel;

   assign cur_bit     = active ? (NUM_QUEUES'(1) << cur_q) : '0;
   assign busy_mask   = pending | cur_bit;
   assign rd          = cur_bit;  // one read per active cycle
   assign rd_addr     = rd_ptr;
   assign end_of_copy = ({1'b0, rd_ptr} == cur_len - 1'b1);

   // lowest numbered pending queue wins
   always_comb begin
      pick_q = '0;
      for (int i = NUM_QUEUES - 1; i >= 0; i--) begin
         if (pending[i]) begin
            pick_q = QW'(i);
         end
      end
   end

   always_ff @(posedge axis_aclk) begin
      if (rst) begin
         pending     <= '0;
         active      <= 1'b0;
         cur_q       <= '0;
         out_q       <= '0;
         rd_ptr      <= '0;
         cur_len     <= '0;
         copies_left <= '0;
      end else begin
         pending <= pending | (start & ~busy_mask);  // repeat starts are dropped
         if (active) begin
            out_q <= cur_q;
            if (end_of_copy) begin
               rd_ptr      <= '0;
               copies_left <= copies_left - 1'b1;
               if (copies_left == REG_WIDTH'(1)) begin
                  active <= 1'b0;
               end
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end else if (|pending) begin
            pending[pick_q] <= 1'b0;
            // count may have been rewritten to zero while waiting
            active      <= |counts[pick_q];
            cur_q       <= pick_q;
            rd_ptr      <= '0;
            cur_len     <= lens[pick_q];
            copies_left <= counts[pick_q];
         end
      end
   end

   // retag the stored word with its queue as destination
   always_comb begin
      sel      = rd_words[out_q];
      out_word = sel;
      out_word.user.dst_port = sel.valid ? (8'(1) << out_q) : 8'd0;
   end

endmodule

`default_nettype wire

// ==== logic/pcap_replay_top.sv ====
// top level of the capture and replay engine, connecting registers, capture, queues and replay
`timescale 1ns/1ps
`default_nettype none

module pcap_replay_top import replay_pkg::*; #(
   parameter int  NUM_QUEUES  = NUM_QUEUES_DEF,
   parameter int  QUEUE_DEPTH = QUEUE_DEPTH_DEF,
   localparam int AW          = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1
) (
   input  logic                      axis_aclk,
   input  logic                      rst,
   input  stream_word_t              in_word,
   input  logic                      reg_wr,
   input  logic                      reg_rd,
   input  logic [REG_ADDR_WIDTH-1:0] reg_addr,
   input  reg_word_u                 reg_wdata,
   output reg_word_u                 reg_rdata,
   output logic                      reg_rvalid,
   output stream_word_t              out_word
);

   logic [NUM_QUEUES-1:0] cap_enable;
   logic [NUM_QUEUES-1:0] start;
   logic [NUM_QUEUES-1:0] ready;
   logic [NUM_QUEUES-1:0] q_wr;
   logic [NUM_QUEUES-1:0] rd;
   logic [REG_WIDTH-1:0]  counts [NUM_QUEUES];
   logic                  q_first;
   stream_word_t          q_word;
   stream_word_t          rd_words [NUM_QUEUES];
   logic [AW:0]           lens [NUM_QUEUES];
   logic [AW-1:0]         rd_addr;

   replay_regs #(.NUM_QUEUES(NUM_QUEUES)) u_regs (
      .axis_aclk (axis_aclk), .rst (rst),
      .reg_wr (reg_wr), .reg_rd (reg_rd), .reg_addr (reg_addr), .reg_wdata (reg_wdata),
      .ready (ready), .reg_rdata (reg_rdata), .reg_rvalid (reg_rvalid),
      .cap_enable (cap_enable), .start (start), .counts (counts)
   );

   capture_demux #(.NUM_QUEUES(NUM_QUEUES)) u_capture (
      .axis_aclk (axis_aclk), .rst (rst), .in_word (in_word), .cap_enable (cap_enable),
      .q_wr (q_wr), .q_first (q_first), .q_word (q_word)
   );

   // one packet store per queue, all sharing the replay read address
   for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
      queue_store #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_store (
         .axis_aclk (axis_aclk), .rst (rst),
         .wr (q_wr[q]), .first (q_first), .wr_word (q_word),
         .rd (rd[q]), .rd_addr (rd_addr), .rd_word (rd_words[q]),
         .pkt_len_words (lens[q]), .pkt_ready (ready[q])
      );
   end

   replay_engine #(.NUM_QUEUES(NUM_QUEUES), .QUEUE_DEPTH(QUEUE_DEPTH)) u_replay (
      .axis_aclk (axis_aclk), .rst (rst), .start (start), .counts (counts),
      .rd_words (rd_words), .lens (lens), .rd (rd), .rd_addr (rd_addr),
      .out_word (out_word)
   );

endmodule

`default_nettype wire

// ==== dv/replay_clkgen.sv ====
// testbench clock and reset source, drives axis_aclk and holds rst for the first cycles
`timescale 1ns/1ps
`default_nettype none

module replay_clkgen #(
   parameter real PERIOD_NS    = 4.0,
   parameter int  RESET_CYCLES = 10
) (
   output logic axis_aclk,
   output logic rst
);

   initial begin
      axis_aclk = 1'b0;
      forever #(PERIOD_NS / 2.0) axis_aclk = ~axis_aclk;
   end

   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge axis_aclk);
      rst <= 1'b0;  // released on an edge like any other input
   end

endmodule

`default_nettype wire

// ==== dv/replay_checker.sv ====
// protocol assertions on the replay engine top level, attached to it by bind from the testbench
`timescale 1ns/1ps
`default_nettype none

module replay_checker import replay_pkg::*; (
   input logic         axis_aclk,
   input logic         rst,
   input logic         reg_rd,
   input logic         reg_rvalid,
   input stream_word_t out_word
);

   // both valids come up low once a reset edge has been seen
   reset_quiet: assert property (@(posedge axis_aclk)
      rst |=> !out_word.valid && !reg_rvalid)
      else $error("output or read response valid while in reset");

   last_with_valid: assert property (@(posedge axis_aclk) disable iff (rst)
      out_word.last |-> out_word.valid)
      else $error("last seen on an output word without valid");

   keep_not_empty: assert property (@(posedge axis_aclk) disable iff (rst)
      out_word.valid |-> (out_word.keep != '0))
      else $error("output word valid with no byte enabled");

   // read response exactly one cycle after the strobe
   rvalid_after_rd: assert property (@(posedge axis_aclk) disable iff (rst)
      reg_rd |=> reg_rvalid)
      else $error("register read strobe got no response the next cycle");

   rvalid_needs_rd: assert property (@(posedge axis_aclk) disable iff (rst)
      reg_rvalid |-> $past(reg_rd))
      else $error("register read response without a strobe the cycle before");

endmodule

`default_nettype wire

// ==== dv/replay_tb.sv ====
// testbench for the capture and replay engine that captures random packets and checks every replay
`timescale 1ns/1ps
`default_nettype none

module replay_tb import replay_pkg::*; ();

   localparam int NQ    = NUM_QUEUES_DEF;
   localparam int DEPTH = QUEUE_DEPTH_DEF;

   logic                      axis_aclk;
   logic                      rst;
   stream_word_t              in_word;
   stream_word_t              out_word;
   logic                      reg_wr;
   logic                      reg_rd;
   logic [REG_ADDR_WIDTH-1:0] reg_addr;
   reg_word_u                 reg_wdata;
   reg_word_u                 reg_rdata;
   logic                      reg_rvalid;

   logic [31:0]           lcg_state = 32'd69961;
   int                    mismatches = 0;
   int                    failures = 0;      // timeouts and stray words
   stream_word_t          exp_q [$];         // expected output in order
   logic [DATA_WIDTH-1:0] m_data [NQ][DEPTH];
   logic [KEEP_WIDTH-1:0] m_keep [NQ][DEPTH];
   tuser_t                m_user [NQ];
   int                    m_len [NQ];
   logic [REG_WIDTH-1:0]  m_count [NQ];
   logic [NQ-1:0]         m_stored = '0;
   logic [NQ-1:0]         m_enable = '0;

   replay_clkgen u_clkgen (.axis_aclk (axis_aclk), .rst (rst));

   pcap_replay_top #(.NUM_QUEUES(NQ), .QUEUE_DEPTH(DEPTH)) UUT (
      .axis_aclk (axis_aclk), .rst (rst), .in_word (in_word),
      .reg_wr (reg_wr), .reg_rd (reg_rd), .reg_addr (reg_addr), .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata), .reg_rvalid (reg_rvalid), .out_word (out_word)
   );

   bind pcap_replay_top replay_checker u_checker (
      .axis_aclk (axis_aclk), .rst (rst), .reg_rd (reg_rd),
      .reg_rvalid (reg_rvalid), .out_word (out_word)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic reg_write(input logic [REG_ADDR_WIDTH-1:0] addr,
                            input logic [REG_WIDTH-1:0] value);
      @(posedge axis_aclk);
      reg_wr          <= 1'b1;
      reg_addr        <= addr;
      reg_wdata.count <= value;
      @(posedge axis_aclk);
      reg_wr <= 1'b0;
      if (addr == REG_ENABLE) begin
         m_enable = value[NQ-1:0];
      end
      if (addr >= REG_COUNT_BASE && addr < REG_COUNT_BASE + 3'(NQ)) begin
         m_count[addr - REG_COUNT_BASE] = value;
      end
   endtask

   task automatic reg_read(input logic [REG_ADDR_WIDTH-1:0] addr, output reg_word_u value);
      int tries;
      @(posedge axis_aclk);
      reg_rd   <= 1'b1;
      reg_addr <= addr;
      @(posedge axis_aclk);
      reg_rd <= 1'b0;
      tries = 0;
      do begin
         @(negedge axis_aclk);
         tries++;
      end while (!reg_rvalid && tries < 4);
      if (!reg_rvalid) begin
         $display("Error at %0t: no read response for register %0d", $time, addr);
         failures++;
      end
      value = reg_rdata;
   endtask

   task automatic check_reg(input logic [REG_ADDR_WIDTH-1:0] addr,
                            input logic [REG_WIDTH-1:0] expected);
      reg_word_u got;
      reg_read(addr, got);
      assert (got.count === expected) else begin
         $display("Mismatch at %0t: register %0d read %h, expected %h",
                  $time, addr, got.count, expected);
         mismatches++;
      end
   endtask

   // random packet steered to queue q and recorded only if that queue captures
   task automatic send_packet(input int q);
      int               n;
      logic [7:0]       last_keep;
      stream_word_t     w;
      n = 1 + int'(lcg_next() % 10);
      last_keep = 8'hff >> (lcg_next() % 8);
      w = '0;
      w.valid = 1'b1;
      w.user.src_port = 8'(1) << q;
      w.user.pkt_len  = 16'((n - 1) * 8 + $countones(last_keep));  // bytes
      for (int i = 0; i < n; i++) begin
         w.data = {lcg_next(), lcg_next()};
         w.keep = (i == n - 1) ? last_keep : 8'hff;
         w.last = (i == n - 1);
         @(posedge axis_aclk);
         in_word <= w;
         if (m_enable[q]) begin
            m_data[q][i] = w.data;
            m_keep[q][i] = w.keep;
         end
      end
      @(posedge axis_aclk);
      in_word <= '0;
      if (m_enable[q]) begin
         m_len[q]    = n;
         m_user[q]   = w.user;
         m_stored[q] = 1'b1;
      end
   endtask

   task automatic wait_stored(input logic [NQ-1:0] mask);
      reg_word_u got;
      int        tries;
      tries = 0;
      do begin
         reg_read(REG_STATUS, got);
         tries++;
      end while ((got.mask.queues[NQ-1:0] & mask) != mask && tries < 20);
      if ((got.mask.queues[NQ-1:0] & mask) != mask) begin
         $display("Error at %0t: queues %b never reported a stored packet", $time, mask);
         failures++;
      end
   endtask

   // queues are served lowest first with each copy back to back
   task automatic start_queues(input logic [NQ-1:0] mask);
      stream_word_t w;
      reg_write(REG_START, REG_WIDTH'(mask));
      for (int q = 0; q < NQ; q++) begin
         if (mask[q] && m_stored[q] && m_count[q] != 0) begin
            w = '0;
            w.valid = 1'b1;
            w.user  = m_user[q];
            w.user.dst_port = 8'(1) << q;
            for (int c = 0; c < int'(m_count[q]); c++) begin
               for (int i = 0; i < m_len[q]; i++) begin
                  w.data = m_data[q][i];
                  w.keep = m_keep[q][i];
                  w.last = (i == m_len[q] - 1);
                  exp_q.push_back(w);
               end
            end
         end
      end
   endtask

   task automatic wait_drained(input string what);
      int tries;
      tries = 0;
      while (exp_q.size() != 0 && tries < 1000) begin
         @(negedge axis_aclk);
         tries++;
      end
      if (exp_q.size() != 0) begin
         $display("Error at %0t: timeout waiting for replay of %s", $time, what);
         failures++;
         exp_q.delete();
      end
   endtask

   always @(negedge axis_aclk) begin
      if (!rst && out_word.valid) begin
         if (exp_q.size() == 0) begin
            $display("Error at %0t: output word while no replay was expected", $time);
            failures++;
         end else begin
            assert (out_word === exp_q[0]) else begin
               $display("Mismatch at %0t: output %h, expected %h", $time, out_word, exp_q[0]);
               mismatches++;
            end
            void'(exp_q.pop_front());
         end
      end
   end

   initial begin
      int tries;
      in_word   = '0;
      reg_wr    = 1'b0;
      reg_rd    = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;
      for (int q = 0; q < NQ; q++) begin
         m_count[q] = '0;
      end
      tries = 0;
      do begin
         @(posedge axis_aclk);
         tries++;
      end while (rst !== 1'b0 && tries < 40);
      if (rst !== 1'b0) begin
         $display("Error at %0t: reset never released", $time);
         failures++;
      end

      reg_write(REG_COUNT_BASE, 32'd2);
      reg_write(REG_COUNT_BASE + 3'd1, 32'd1);
      reg_write(REG_COUNT_BASE + 3'd2, 32'd3);
      reg_write(REG_ENABLE, 32'h7);  // last queue left disabled
      check_reg(REG_ENABLE, 32'h7);
      for (int q = 0; q < 3; q++) begin
         check_reg(REG_COUNT_BASE + 3'(q), m_count[q]);
      end
      for (int q = 0; q < NQ; q++) begin
         send_packet(q);
      end
      wait_stored(4'b0111);
      check_reg(REG_STATUS, REG_WIDTH'(m_stored));  // dropped packet leaves bit 3 low

      start_queues(4'b0001);
      wait_drained("queue 0");
      start_queues(4'b0110);
      wait_drained("queues 1 and 2 started together");

      // count without a packet and a packet without a count
      reg_write(REG_COUNT_BASE + 3'd3, 32'd2);
      reg_write(REG_COUNT_BASE, 32'd0);
      start_queues(4'b1001);
      repeat (100) @(negedge axis_aclk);

      reg_write(REG_ENABLE, 32'hf);
      send_packet(3);
      wait_stored(4'b1000);
      check_reg(REG_STATUS, REG_WIDTH'(m_stored));
      check_reg(REG_COUNT_BASE + 3'd3, 32'd2);
      start_queues(4'b1000);
      wait_drained("queue 3");
      repeat (20) @(negedge axis_aclk);  // nothing more may come out

      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
logic/replay_pkg.sv
logic/replay_regs.sv
logic/capture_demux.sv
logic/queue_store.sv
logic/replay_engine.sv
logic/pcap_replay_top.sv
dv/replay_clkgen.sv
dv/replay_checker.sv
dv/replay_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = replay_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
